/* sources.f */
+incdir+include
source/rf_pkg.sv
source/wb_pkg.sv
source/rf_bank_ram.sv
source/rf_banked_4r2w.sv
source/rf_wb_queue.sv
source/rf_retire.sv
source/rf_wb_slave.sv
source/rf_subsys_top.sv
testbench/tb_rf_subsys.sv

/* Makefile */
TOP = tb_rf_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation reported errors"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* testbench/tb_rf_subsys.sv */
`timescale 1ns/1ps
`include "rf_defs.svh"

module tb_rf_subsys;

    localparam int ACK_LIMIT = 200;

    logic                clk;
    logic                rst_n;
    wb_pkg::wb_req_t     wb_req;
    wb_pkg::wb_rsp_t     wb_rsp;
    logic [`RF_AW-1:0]   ra0;
    logic [`RF_AW-1:0]   ra1;
    logic [`RF_AW-1:0]   ra2;
    logic [`RF_XLEN-1:0] rd0;
    logic [`RF_XLEN-1:0] rd1;
    logic [`RF_XLEN-1:0] rd2;

    // reference model of the register file
    logic [`RF_XLEN-1:0] model [`RF_NREGS];
    integer              seed;
    int                  checks;
    int                  errors;
    int                  timeouts;
    logic [31:0]         rnd;
    logic [31:0]         rdata;
    logic [31:0]         st_before;
    logic [31:0]         st_after;
    logic [31:0]         pred;
    logic [7:0]          par;
    bit                  ok;
    int                  pat [8];

    rf_subsys_top dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp),
        .ra0_i    (ra0),
        .ra1_i    (ra1),
        .ra2_i    (ra2),
        .rd0_o    (rd0),
        .rd1_o    (rd1),
        .rd2_o    (rd2)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail %s: expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    // classic cycle, ack sampled mid-cycle, stb dropped on the edge after ack
    task automatic bus_write(input logic [5:0] adr, input logic [31:0] dat, input string name,
                             input int limit, input bit may_stall, output bit acked);
        wb_pkg::wb_req_t req;
        int              n;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = 1'b1;
        req.adr = adr;
        req.dat = dat;
        @(posedge clk);
        wb_req <= req;
        acked = 1'b0;
        n = 0;
        while (!acked && n < limit) begin
            @(negedge clk);
            acked = wb_rsp.ack;
            n++;
        end
        @(posedge clk);
        wb_req <= '0;
        if (acked && adr < 6'(`RF_NREGS)) begin
            model[adr[4:0]] = dat;
        end
        if (!acked && !may_stall) begin
            $display("timeout: no ack for write to adr %0d in %s", adr, name);
            timeouts++;
        end
    endtask

    task automatic bus_read(input logic [5:0] adr, input string name,
                            output logic [31:0] dat, output bit acked);
        wb_pkg::wb_req_t req;
        int              n;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.adr = adr;
        @(posedge clk);
        wb_req <= req;
        acked = 1'b0;
        dat = 'x;
        n = 0;
        while (!acked && n < ACK_LIMIT) begin
            @(negedge clk);
            acked = wb_rsp.ack;
            dat = wb_rsp.dat;
            n++;
        end
        @(posedge clk);
        wb_req <= '0;
        if (!acked) begin
            $display("timeout: no ack for read of adr %0d in %s", adr, name);
            timeouts++;
        end
    endtask

    task automatic check_all_regs(input string name);
        logic [31:0] val;
        bit          acked;
        for (int i = 0; i < `RF_NREGS; i++) begin
            bus_read(6'(i), name, val, acked);
            if (acked) begin
                check_value(name, model[i[4:0]], val);
            end
        end
    endtask

    // issue ports sampled at random addresses, then the same register over the bus
    task automatic check_read_ports(input string name);
        logic [31:0] r;
        logic [31:0] val;
        bit          acked;
        r = $random(seed);
        @(posedge clk);
        ra0 <= r[4:0];
        ra1 <= r[9:5];
        ra2 <= r[14:10];
        @(negedge clk);
        check_value(name, model[r[4:0]], rd0);
        check_value(name, model[r[9:5]], rd1);
        check_value(name, model[r[14:10]], rd2);
        bus_read({1'b0, r[4:0]}, name, val, acked);
        if (acked) begin
            check_value(name, model[r[4:0]], val);
        end
    endtask

    // pair when head parities differ, else single, conflict if a pair was there
    function automatic logic [31:0] predict_retire(input logic [7:0] p, input int n);
        int i;
        int duals;
        int confl;
        i = 0;
        duals = 0;
        confl = 0;
        while (i < n) begin
            if (i + 1 < n && p[i[2:0]] != p[3'(i + 1)]) begin
                duals++;
                i += 2;
            end else begin
                if (i + 1 < n) begin
                    confl++;
                end
                i++;
            end
        end
        return {16'(confl), 16'(duals)};
    endfunction

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        wb_req = '0;
        ra0 = '0;
        ra1 = '0;
        ra2 = '0;
        seed = 32'ha1c5;
        checks = 0;
        errors = 0;
        timeouts = 0;
        par = '0;
        pat = '{2, 7, 4, 4, 9, 11, 13, 6};
        for (int i = 0; i < `RF_NREGS; i++) begin
            model[i[4:0]] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // first read only completes once the sweep is over
        bus_read(6'd5, "clear", rdata, ok);
        check_all_regs("clear");
        repeat (4) check_read_ports("clear_ports");

        for (int i = 0; i < `RF_NREGS; i++) begin
            rnd = $random(seed);
            bus_write(6'(i), rnd, "readback", ACK_LIMIT, 1'b0, ok);
        end
        check_all_regs("readback");

        bus_read(6'd0, "read_ports", rdata, ok);
        repeat (8) check_read_ports("read_ports");

        // queue fills under hold, then drains with a known parity pattern
        bus_read(6'(`RF_WB_STATUS_ADR), "pair_retire", st_before, ok);
        bus_write(6'(`RF_WB_CTRL_ADR), 32'd1, "pair_retire", ACK_LIMIT, 1'b0, ok);
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            bus_write(6'(pat[k]), rnd, "pair_retire", ACK_LIMIT, 1'b0, ok);
            par[k[2:0]] = pat[k][0];
        end
        bus_write(6'(`RF_WB_CTRL_ADR), 32'd0, "pair_retire", ACK_LIMIT, 1'b0, ok);
        pred = predict_retire(par, 8);
        bus_read(6'd0, "pair_retire", rdata, ok);
        bus_read(6'(`RF_WB_STATUS_ADR), "pair_retire", st_after, ok);
        check_value("pair_retire_dual", {16'd0, pred[15:0]},
                    {16'd0, st_after[15:0] - st_before[15:0]});
        check_value("pair_retire_conflict", {16'd0, pred[31:16]},
                    {16'd0, st_after[31:16] - st_before[31:16]});
        check_all_regs("pair_retire");

        bus_write(6'(`RF_WB_CTRL_ADR), 32'd1, "backpressure", ACK_LIMIT, 1'b0, ok);
        for (int k = 0; k < 10; k++) begin
            rnd = $random(seed);
            if (k == 8) begin
                // the queue is full, this one has to stall
                bus_write(6'(20 + k), rnd, "backpressure", 20, 1'b1, ok);
                checks++;
                assert (!ok) else begin
                    $display("ninth write was acknowledged while the queue was full");
                    errors++;
                end
                bus_write(6'(`RF_WB_CTRL_ADR), 32'd0, "backpressure", ACK_LIMIT, 1'b0, ok);
            end
            bus_write(6'(20 + k), rnd, "backpressure", ACK_LIMIT, 1'b0, ok);
        end
        check_all_regs("backpressure");

        bus_write(6'(`RF_WB_CTRL_ADR), 32'd1, "ctrl", ACK_LIMIT, 1'b0, ok);
        bus_read(6'(`RF_WB_CTRL_ADR), "ctrl", rdata, ok);
        check_value("ctrl_hold_set", 32'd1, rdata);
        bus_write(6'(`RF_WB_CTRL_ADR), 32'd0, "ctrl", ACK_LIMIT, 1'b0, ok);
        bus_read(6'(`RF_WB_CTRL_ADR), "ctrl", rdata, ok);
        check_value("ctrl_hold_clear", 32'd0, rdata);

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* source/rf_subsys_top.sv */
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_subsys_top (
    input  logic                clk,
    input  logic                rst_n,
    input  wb_pkg::wb_req_t     wb_req_i,
    output wb_pkg::wb_rsp_t     wb_rsp_o,
    input  logic [`RF_AW-1:0]   ra0_i,
    input  logic [`RF_AW-1:0]   ra1_i,
    input  logic [`RF_AW-1:0]   ra2_i,
    output logic [`RF_XLEN-1:0] rd0_o,
    output logic [`RF_XLEN-1:0] rd1_o,
    output logic [`RF_XLEN-1:0] rd2_o
);

    rf_pkg::rf_wbq_entry_t push_data, head0, head1;
    rf_pkg::rf_wr_t        wr0, wr1;
    logic                  push, full, empty, hold, retire_idle;
    logic                  conflict, init_busy;
    logic [1:0]            pop_cnt;
    logic [3:0]            count;
    logic [15:0]           dual_cnt, conflict_cnt;
    logic [`RF_AW-1:0]     wb_rd_addr;
    logic [`RF_XLEN-1:0]   wb_rd_data;

    rf_wb_slave u_slave (
        .clk, .rst_n, .wb_req_i, .wb_rsp_o,
        .push_o (push), .push_data_o (push_data),
        .full_i (full), .empty_i (empty), .retire_idle_i (retire_idle),
        .rd_addr_o (wb_rd_addr), .rd_data_i (wb_rd_data),
        .dual_cnt_i (dual_cnt), .conflict_cnt_i (conflict_cnt), .hold_o (hold)
    );

    rf_wb_queue #(.DEPTH(`RF_WBQ_DEPTH)) u_queue (
        .clk, .rst_n, .push_i (push), .push_data_i (push_data), .pop_cnt_i (pop_cnt),
        .head0_o (head0), .head1_o (head1), .count_o (count),
        .full_o (full), .empty_o (empty)
    );

    rf_retire u_retire (
        .clk, .rst_n, .hold_i (hold), .init_busy_i (init_busy),
        .head0_i (head0), .head1_i (head1), .count_i (count), .conflict_i (conflict),
        .pop_cnt_o (pop_cnt), .wr0_o (wr0), .wr1_o (wr1), .idle_o (retire_idle),
        .dual_cnt_o (dual_cnt), .conflict_cnt_o (conflict_cnt)
    );

    // read port 3 serves wishbone readback
    rf_banked_4r2w #(.WIDTH(`RF_XLEN)) u_rf (
        .clk, .rst_n, .ra0_i, .ra1_i, .ra2_i, .ra3_i (wb_rd_addr),
        .rd0_o, .rd1_o, .rd2_o, .rd3_o (wb_rd_data),
        .wr0_i (wr0), .wr1_i (wr1), .conflict_o (conflict), .init_busy_o (init_busy)
    );

endmodule

/* source/rf_wb_slave.sv */
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_wb_slave (
    input  logic                  clk,
    input  logic                  rst_n,
    input  wb_pkg::wb_req_t       wb_req_i,
    output wb_pkg::wb_rsp_t       wb_rsp_o,
    output logic                  push_o,
    output rf_pkg::rf_wbq_entry_t push_data_o,
    input  logic                  full_i,
    input  logic                  empty_i,
    input  logic                  retire_idle_i,
    output logic [`RF_AW-1:0]     rd_addr_o,
    input  logic [`RF_XLEN-1:0]   rd_data_i,
    input  logic [15:0]           dual_cnt_i,
    input  logic [15:0]           conflict_cnt_i,
    output logic                  hold_o
);

    wb_pkg::wb_slave_state_e state_q;
    wb_pkg::wb_region_e      region;
    logic                    req_valid;
    logic                    drained;
    logic                    ack_q;
    logic                    push_q;
    logic                    hold_q;
    logic [`RF_XLEN-1:0]     rsp_dat_q;
    rf_pkg::rf_wbq_entry_t   push_data_q;

    assign req_valid = wb_req_i.cyc && wb_req_i.stb;
    assign drained   = empty_i && retire_idle_i;
    assign rd_addr_o = wb_req_i.adr[`RF_AW-1:0];

    // unmapped high addresses fall into the status region and read zero
    always_comb begin
        region = wb_pkg::REGION_STATUS;
        if (wb_req_i.adr < 6'(`RF_NREGS)) begin
            region = wb_pkg::REGION_GPR;
        end else if (wb_req_i.adr == 6'(`RF_WB_CTRL_ADR)) begin
            region = wb_pkg::REGION_CTRL;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= wb_pkg::IDLE;
            ack_q   <= 1'b0;
            push_q  <= 1'b0;
            hold_q  <= 1'b0;
        end else begin
            ack_q  <= 1'b0;
            push_q <= 1'b0;
            case (state_q)
                wb_pkg::IDLE: begin
                    if (req_valid) begin
                        if (region == wb_pkg::REGION_GPR) begin
                            if (wb_req_i.we) begin
                                // retry every cycle while the queue is full
                                if (!full_i) begin
                                    push_q  <= 1'b1;
                                    ack_q   <= 1'b1;
                                    state_q <= wb_pkg::ACK;
                                end
                            end else if (drained) begin
                                ack_q   <= 1'b1;
                                state_q <= wb_pkg::ACK;
                            end else begin
                                state_q <= wb_pkg::WAIT_DRAIN;
                            end
                        end else begin
                            if (region == wb_pkg::REGION_CTRL && wb_req_i.we) begin
                                hold_q <= wb_req_i.dat[0];
                            end
                            ack_q   <= 1'b1;
                            state_q <= wb_pkg::ACK;
                        end
                    end
                end
                wb_pkg::WAIT_DRAIN: begin
                    if (drained) begin
                        ack_q   <= 1'b1;
                        state_q <= wb_pkg::ACK;
                    end
                end
                default: state_q <= wb_pkg::IDLE;
            endcase
        end
    end

    // payload capture, frozen while ack is out
    always_ff @(posedge clk) begin
        if (state_q != wb_pkg::ACK) begin
            push_data_q.addr <= wb_req_i.adr[`RF_AW-1:0];
            push_data_q.data <= wb_req_i.dat;
            case (region)
                wb_pkg::REGION_GPR:  rsp_dat_q <= rd_data_i;
                wb_pkg::REGION_CTRL: rsp_dat_q <= {{(`RF_XLEN-1){1'b0}}, hold_q};
                default: begin
                    rsp_dat_q <= (wb_req_i.adr == 6'(`RF_WB_STATUS_ADR)) ?
                                 {conflict_cnt_i, dual_cnt_i} : '0;
                end
            endcase
        end
    end

    assign push_o       = push_q;
    assign push_data_o  = push_data_q;
    assign hold_o       = hold_q;
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rsp_dat_q;

    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb)
    );

endmodule

/* source/rf_retire.sv */
`timescale 1ns/1ps

module rf_retire (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  hold_i,
    input  logic                  init_busy_i,
    input  rf_pkg::rf_wbq_entry_t head0_i,
    input  rf_pkg::rf_wbq_entry_t head1_i,
    input  logic [3:0]            count_i,
    input  logic                  conflict_i,
    output logic [1:0]            pop_cnt_o,
    output rf_pkg::rf_wr_t        wr0_o,
    output rf_pkg::rf_wr_t        wr1_o,
    output logic                  idle_o,
    output logic [15:0]           dual_cnt_o,
    output logic [15:0]           conflict_cnt_o
);

    rf_pkg::rf_retire_state_e state_q;
    logic                     active;
    logic                     pair_avail;
    logic                     dual;

    assign active     = (state_q != rf_pkg::INIT_WAIT) && !hold_i && (count_i != 4'd0);
    assign pair_avail = active && (count_i >= 4'd2);
    // same bank pairs go one at a time
    assign dual       = pair_avail && !conflict_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q        <= rf_pkg::INIT_WAIT;
            dual_cnt_o     <= '0;
            conflict_cnt_o <= '0;
        end else begin
            case (state_q)
                rf_pkg::INIT_WAIT: if (!init_busy_i) state_q <= rf_pkg::IDLE;
                rf_pkg::IDLE:      if (active) state_q <= rf_pkg::DRAIN;
                default:           if (!active) state_q <= rf_pkg::IDLE;
            endcase
            if (dual) begin
                dual_cnt_o <= dual_cnt_o + 16'd1;
            end
            if (pair_avail && conflict_i) begin
                conflict_cnt_o <= conflict_cnt_o + 16'd1;
            end
        end
    end

    always_comb begin
        wr0_o.addr = head0_i.addr;
        wr0_o.data = head0_i.data;
        wr0_o.en   = active;
        wr1_o.addr = head1_i.addr;
        wr1_o.data = head1_i.data;
        wr1_o.en   = dual;
        pop_cnt_o  = dual ? 2'd2 : {1'b0, active};
    end

    assign idle_o = state_q == rf_pkg::IDLE;

    // with hold set the queue count never drops
    a_hold_no_pop: assert property (
        @(posedge clk) disable iff (!rst_n)
        hold_i |=> (count_i >= $past(count_i))
    );

endmodule

/* source/rf_wb_queue.sv */
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_wb_queue #(
    parameter int DEPTH = `RF_WBQ_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push_i,
    input  rf_pkg::rf_wbq_entry_t push_data_i,
    input  logic [1:0]            pop_cnt_i,
    output rf_pkg::rf_wbq_entry_t head0_o,
    output rf_pkg::rf_wbq_entry_t head1_o,
    output logic [3:0]            count_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PW = $clog2(DEPTH);

    rf_pkg::rf_wbq_entry_t mem [DEPTH];
    logic [PW-1:0]         wr_ptr_q;
    logic [PW-1:0]         rd_ptr_q;
    logic [3:0]            count_q;

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + PW'(1);
            end
            rd_ptr_q <= rd_ptr_q + PW'(pop_cnt_i);
            count_q  <= count_q + {3'b0, push_i} - {2'b0, pop_cnt_i};
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    assign head0_o = mem[rd_ptr_q];
    assign head1_o = mem[rd_ptr_q + PW'(1)];
    assign count_o = count_q;
    assign full_o  = count_q == 4'(DEPTH);
    assign empty_o = count_q == 4'd0;

    a_no_push_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o
    );

    a_no_over_pop: assert property (
        @(posedge clk) disable iff (!rst_n)
        {2'b0, pop_cnt_i} <= count_q
    );

endmodule

/* source/rf_banked_4r2w.sv */
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_banked_4r2w #(
    parameter int WIDTH = `RF_XLEN
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`RF_AW-1:0]  ra0_i,
    input  logic [`RF_AW-1:0]  ra1_i,
    input  logic [`RF_AW-1:0]  ra2_i,
    input  logic [`RF_AW-1:0]  ra3_i,
    output logic [WIDTH-1:0]   rd0_o,
    output logic [WIDTH-1:0]   rd1_o,
    output logic [WIDTH-1:0]   rd2_o,
    output logic [WIDTH-1:0]   rd3_o,
    input  rf_pkg::rf_wr_t     wr0_i,
    input  rf_pkg::rf_wr_t     wr1_i,
    output logic               conflict_o,
    output logic               init_busy_o
);

    rf_pkg::rf_wr_t   steer [2];
    logic [3:0]       bank_wa [2];
    logic [WIDTH-1:0] bank_wd [2];
    logic             bank_we [2];
    logic [WIDTH-1:0] dout0 [2];
    logic [WIDTH-1:0] dout1 [2];
    logic [WIDTH-1:0] dout2 [2];
    logic [WIDTH-1:0] dout3 [2];
    logic [3:0]       init_cnt_q;
    logic             init_busy_q;

    assign conflict_o = wr0_i.addr[0] == wr1_i.addr[0];
    assign init_busy_o = init_busy_q;

    // clear sweep, one index per cycle in both banks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_cnt_q  <= '0;
            init_busy_q <= 1'b1;
        end else if (init_busy_q) begin
            init_cnt_q <= init_cnt_q + 4'd1;
            if (init_cnt_q == 4'd15) begin
                init_busy_q <= 1'b0;
            end
        end
    end

    // port 0 takes the bank it addresses, port 1 gets the other one
    assign steer[0] = (wr0_i.en && !wr0_i.addr[0]) ? wr0_i : wr1_i;
    assign steer[1] = (wr0_i.en && wr0_i.addr[0]) ? wr0_i : wr1_i;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        assign bank_wa[b] = init_busy_q ? init_cnt_q : steer[b].addr[`RF_AW-1:1];
        assign bank_wd[b] = init_busy_q ? '0 : steer[b].data;
        assign bank_we[b] = init_busy_q || (steer[b].en && (steer[b].addr[0] == 1'(b)));

        rf_bank_ram #(.WIDTH(WIDTH)) u_ram (
            .clk     (clk),
            .addr0_i (ra0_i[`RF_AW-1:1]),
            .addr1_i (ra1_i[`RF_AW-1:1]),
            .addr2_i (ra2_i[`RF_AW-1:1]),
            .addr3_i (ra3_i[`RF_AW-1:1]),
            .dout0_o (dout0[b]),
            .dout1_o (dout1[b]),
            .dout2_o (dout2[b]),
            .dout3_o (dout3[b]),
            .addrw_i (bank_wa[b]),
            .din_i   (bank_wd[b]),
            .we_i    (bank_we[b])
        );
    end

    // odd addresses live in bank 1
    assign rd0_o = ra0_i[0] ? dout0[1] : dout0[0];
    assign rd1_o = ra1_i[0] ? dout1[1] : dout1[0];
    assign rd2_o = ra2_i[0] ? dout2[1] : dout2[0];
    assign rd3_o = ra3_i[0] ? dout3[1] : dout3[0];

    // the retire unit must split same-bank pairs
    a_no_dual_on_conflict: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(wr0_i.en && wr1_i.en && conflict_o)
    );

endmodule

/* source/rf_bank_ram.sv */
`timescale 1ns/1ps
`include "rf_defs.svh"

module rf_bank_ram #(
    parameter int WIDTH = `RF_XLEN
) (
    input  logic             clk,
    input  logic [3:0]       addr0_i,
    input  logic [3:0]       addr1_i,
    input  logic [3:0]       addr2_i,
    input  logic [3:0]       addr3_i,
    output logic [WIDTH-1:0] dout0_o,
    output logic [WIDTH-1:0] dout1_o,
    output logic [WIDTH-1:0] dout2_o,
    output logic [WIDTH-1:0] dout3_o,
    input  logic [3:0]       addrw_i,
    input  logic [WIDTH-1:0] din_i,
    input  logic             we_i
);

    logic [WIDTH-1:0] mem [16];

    // async reads
    assign dout0_o = mem[addr0_i];
    assign dout1_o = mem[addr1_i];
    assign dout2_o = mem[addr2_i];
    assign dout3_o = mem[addr3_i];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addrw_i] <= din_i;
        end
    end

endmodule

/* source/wb_pkg.sv */
`include "rf_defs.svh"

package wb_pkg;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [5:0]          adr;
        logic [`RF_XLEN-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                ack;
        logic [`RF_XLEN-1:0] dat;
    } wb_rsp_t;

    typedef enum logic [1:0] {IDLE, ACK, WAIT_DRAIN} wb_slave_state_e;

    // decoded from adr
    typedef enum logic [1:0] {
        REGION_GPR,
        REGION_STATUS,
        REGION_CTRL
    } wb_region_e;

endpackage

/* source/rf_pkg.sv */
`include "rf_defs.svh"

package rf_pkg;

    // one register file write port
    typedef struct packed {
        logic [`RF_AW-1:0]   addr;
        logic [`RF_XLEN-1:0] data;
        logic                en;
    } rf_wr_t;

    // queued writeback from the host
    typedef struct packed {
        logic [`RF_AW-1:0]   addr;
        logic [`RF_XLEN-1:0] data;
    } rf_wbq_entry_t;

    typedef enum logic [1:0] {
        INIT_WAIT,
        IDLE,
        DRAIN
    } rf_retire_state_e;

endpackage

/* include/rf_defs.svh */
`ifndef RF_DEFS_SVH
`define RF_DEFS_SVH

// register file geometry
`define RF_XLEN 32
`define RF_NREGS 32
`define RF_AW 5

// writeback queue entries
`define RF_WBQ_DEPTH 8

// word addresses above the gpr window
`define RF_WB_STATUS_ADR 32
`define RF_WB_CTRL_ADR 33

`endif
